/* src/img_pkg.sv */
package img_pkg;

    // ====================
    // Frame and store sizes
    // ====================
    localparam int IMAGE_WIDTH_MAX  = 32;
    localparam int IMAGE_HEIGHT_MAX = 32;
    localparam int BLOCK_SIZE       = IMAGE_WIDTH_MAX * IMAGE_HEIGHT_MAX;
    localparam int BLOCK_COUNT      = 2;

    // Counters must hold the maxima themselves
    localparam int WIDTH_W  = 6;
    localparam int HEIGHT_W = 6;

    // Pixel sits in the low bits of a word with zero top bits
    localparam int PIXEL_W   = 12;
    localparam int WORD_W    = 16;
    localparam int STAT_W    = 18;
    localparam int STAT_BITS = 7;

    // ====================
    // Store commands
    // ====================
    localparam int CMD_W = 2;
    localparam logic [CMD_W-1:0] CMD_NONE  = 2'd0;
    localparam logic [CMD_W-1:0] CMD_WRITE = 2'd1;
    localparam logic [CMD_W-1:0] CMD_READ  = 2'd2;
    localparam logic [CMD_W-1:0] CMD_STOP  = 2'd3;

    // ====================
    // Buffering and timing
    // ====================
    localparam int FIFO_DEPTH        = 16;
    // Store refuses writes this long after reset as an SDRAM does at power-up
    localparam int STORE_INIT_CYCLES = 40;

endpackage

/* src/word_fifo.sv */
`timescale 1ns/100ps

module word_fifo
    import img_pkg::*;
(
    input  logic              clk,
    input  logic              fifoIn_rst,
    input  logic              flush,
    output logic              write_ready,
    input  logic              write_trigger,
    input  logic [WORD_W-1:0] write_data,
    output logic              read_ready,
    input  logic              read_trigger,
    output logic [WORD_W-1:0] read_data
);
    localparam int PTR_W = $clog2(FIFO_DEPTH);

    logic [WORD_W-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [PTR_W:0]    count;
    logic              do_write;
    logic              do_read;

    assign write_ready = (count != (PTR_W + 1)'(FIFO_DEPTH));
    assign read_ready  = (count != '0);
    assign do_write    = write_ready && write_trigger;
    assign do_read     = read_ready && read_trigger;
    assign read_data   = mem[rd_ptr];

    // Pointers wrap naturally because the depth is a power of two
    always_ff @(posedge clk) begin
        if (!fifoIn_rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) wr_ptr <= wr_ptr + 1'b1;
            if (do_read) rd_ptr <= rd_ptr + 1'b1;
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_write) mem[wr_ptr] <= write_data;
    end

    assert property (@(posedge clk) disable iff (!fifoIn_rst) count <= FIFO_DEPTH);

endmodule

/* src/pixel_capture.sv */
`timescale 1ns/100ps

module pixel_capture
    import img_pkg::*;
(
    input  logic                clk,
    input  logic                fifoIn_rst,
    input  logic                capture_start,
    input  logic [PIXEL_W-1:0]  img_d,
    input  logic                img_fv,
    input  logic                img_lv,
    output logic                in_flush,
    input  logic                in_write_ready,
    output logic                in_write_trigger,
    output logic [WORD_W-1:0]   in_write_data,
    output logic                frame_done,
    output logic [WIDTH_W-1:0]  image_width,
    output logic [HEIGHT_W-1:0] image_height,
    output logic [STAT_W-1:0]   highlight_count,
    output logic [STAT_W-1:0]   shadow_count
);
    localparam logic [2:0] S_IDLE         = 3'd0;
    localparam logic [2:0] S_FLUSH        = 3'd1;
    localparam logic [2:0] S_WAIT_INVALID = 3'd2;
    localparam logic [2:0] S_WAIT_START   = 3'd3;
    localparam logic [2:0] S_FRAME        = 3'd4;

    logic [2:0]           state;
    logic [PIXEL_W-1:0]   d_q;
    logic                 fv_q;
    logic                 lv_q;
    logic                 lv_prev;
    logic [1:0]           x;
    logic [1:0]           y;
    logic                 push;
    logic                 sample;
    logic [STAT_BITS-1:0] top_bits;

    // ====================
    // Sensor registers
    // ====================
    always_ff @(posedge clk) begin
        d_q <= img_d;
    end

    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            fv_q    <= 1'b0;
            lv_q    <= 1'b0;
            lv_prev <= 1'b0;
        end else begin
            fv_q    <= img_fv;
            lv_q    <= img_lv;
            lv_prev <= lv_q;
        end
    end

    // Pixels count from the frame start edge on
    assign in_write_trigger = lv_q && fv_q && (state == S_WAIT_START || state == S_FRAME);
    assign in_write_data    = {{(WORD_W - PIXEL_W){1'b0}}, d_q};
    assign in_flush         = (state == S_FLUSH);
    assign push             = in_write_trigger && in_write_ready;

    // Sample grid where x and y are both multiples of four
    assign top_bits = d_q[PIXEL_W-1 -: STAT_BITS];
    assign sample   = push && (x == 2'd0) && (y == 2'd0);

    // ====================
    // Frame tracking and statistics
    // ====================
    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            state           <= S_IDLE;
            frame_done      <= 1'b0;
            x               <= '0;
            y               <= '0;
            image_width     <= '0;
            image_height    <= '0;
            highlight_count <= '0;
            shadow_count    <= '0;
        end else begin
            if (!lv_q) x <= '0;
            else       x <= x + 2'd1;

            if (!fv_q)                 y <= '0;
            else if (lv_prev && !lv_q) y <= y + 2'd1;

            // First pixel of a line restarts the width and opens a new line
            if (push) begin
                if (!lv_prev) begin
                    image_width  <= WIDTH_W'(1);
                    image_height <= image_height + 1'b1;
                end else begin
                    image_width <= image_width + 1'b1;
                end
            end

            if (sample && (&top_bits)) highlight_count <= highlight_count + 1'b1;
            if (sample && (top_bits == '0)) shadow_count <= shadow_count + 1'b1;

            case (state)
                S_FLUSH:        state <= S_WAIT_INVALID;
                S_WAIT_INVALID: if (!fv_q) state <= S_WAIT_START;
                S_WAIT_START:   if (fv_q) state <= S_FRAME;
                S_FRAME: begin
                    if (!fv_q) begin
                        frame_done <= 1'b1;
                        state      <= S_IDLE;
                    end
                end
                default: ;
            endcase

            // New capture wins over everything above
            if (capture_start) begin
                state           <= S_FLUSH;
                frame_done      <= 1'b0;
                image_width     <= '0;
                image_height    <= '0;
                highlight_count <= '0;
                shadow_count    <= '0;
            end
        end
    end

endmodule

/* src/frame_store.sv */
`timescale 1ns/100ps

module frame_store
    import img_pkg::*;
(
    input  logic              clk,
    input  logic              fifoIn_rst,
    input  logic [CMD_W-1:0]  cmd,
    input  logic              block,
    output logic              write_ready,
    input  logic              write_trigger,
    input  logic [WORD_W-1:0] write_data,
    output logic              read_ready,
    input  logic              read_trigger,
    output logic [WORD_W-1:0] read_data
);
    localparam int ADDR_W = $clog2(BLOCK_COUNT * BLOCK_SIZE);
    localparam int INIT_W = $clog2(STORE_INIT_CYCLES + 1);

    logic [WORD_W-1:0] mem [BLOCK_COUNT * BLOCK_SIZE];
    logic [ADDR_W-1:0] addr;
    logic [INIT_W-1:0] init_count;
    logic              write_mode;
    logic              read_mode;
    logic              sel_block;
    logic              init_done;
    logic              do_write;
    logic              do_read;

    function automatic logic [ADDR_W-1:0] block_base(input logic b);
        return ADDR_W'(BLOCK_SIZE * b);
    endfunction

    assign init_done   = (init_count == INIT_W'(STORE_INIT_CYCLES));
    assign write_ready = write_mode && init_done;
    assign read_ready  = read_mode;
    assign do_write    = write_ready && write_trigger;
    assign do_read     = read_ready && read_trigger;
    assign read_data   = mem[addr];

    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            init_count <= '0;
            write_mode <= 1'b0;
            read_mode  <= 1'b0;
            sel_block  <= 1'b0;
            addr       <= '0;
        end else begin
            // Power-up busy period
            if (!init_done) init_count <= init_count + 1'b1;

            case (cmd)
                CMD_WRITE, CMD_READ: begin
                    write_mode <= (cmd == CMD_WRITE);
                    read_mode  <= (cmd == CMD_READ);
                    sel_block  <= block;
                    addr       <= block_base(block);
                end
                CMD_STOP: begin
                    write_mode <= 1'b0;
                    read_mode  <= 1'b0;
                end
                default: begin
                    if (do_write || do_read) addr <= addr + 1'b1;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_write) mem[addr] <= write_data;
    end

    // Readout count in the sequencer must keep accesses inside one block
    assert property (@(posedge clk) disable iff (!fifoIn_rst)
        (do_write || do_read) |-> ((addr - block_base(sel_block)) < ADDR_W'(BLOCK_SIZE)));

endmodule

/* src/capture_sequencer.sv */
`timescale 1ns/100ps

module capture_sequencer
    import img_pkg::*;
(
    input  logic                clk,
    input  logic                fifoIn_rst,
    input  logic                cmd_capture,
    input  logic                cmd_ram_block,
    output logic                capture_start,
    input  logic                frame_done,
    input  logic [WIDTH_W-1:0]  image_width,
    input  logic [HEIGHT_W-1:0] image_height,
    input  logic                in_read_ready,
    output logic                in_read_trigger,
    input  logic [WORD_W-1:0]   in_read_data,
    output logic [CMD_W-1:0]    store_cmd,
    output logic                store_block,
    input  logic                store_write_ready,
    output logic                store_write_trigger,
    output logic [WORD_W-1:0]   store_write_data,
    input  logic                store_read_ready,
    input  logic                out_write_ready,
    output logic                out_flush,
    output logic                capture_done
);
    localparam logic [2:0] S_IDLE        = 3'd0;
    localparam logic [2:0] S_ISSUE_WRITE = 3'd1;
    localparam logic [2:0] S_WAIT_READY  = 3'd2;
    localparam logic [2:0] S_SYNC        = 3'd3;
    localparam logic [2:0] S_COPY        = 3'd4;
    localparam logic [2:0] S_ISSUE_READ  = 3'd5;
    localparam logic [2:0] S_READOUT     = 3'd6;

    logic [2:0]          state;
    logic                blk;
    logic [WIDTH_W-1:0]  rd_x;
    logic [HEIGHT_W-1:0] rd_y;
    logic                handoff;
    logic                last_word;

    assign store_block   = blk;
    assign capture_start = (state == S_WAIT_READY) && store_write_ready;
    assign out_flush     = (state == S_ISSUE_WRITE) || (state == S_ISSUE_READ);

    // Pop only when the store write slot is free or being taken
    assign in_read_trigger = (state == S_COPY) && (!store_write_trigger || store_write_ready);

    assign handoff   = (state == S_READOUT) && store_read_ready && out_write_ready;
    assign last_word = handoff && (rd_x == WIDTH_W'(1)) && (rd_y == HEIGHT_W'(1));

    // Stop goes out with the last word so no extra word leaves the store
    always_comb begin
        store_cmd = CMD_NONE;
        case (state)
            S_ISSUE_WRITE: store_cmd = CMD_WRITE;
            S_ISSUE_READ:  store_cmd = (image_height == '0) ? CMD_STOP : CMD_READ;
            S_READOUT:     if (last_word) store_cmd = CMD_STOP;
            default:       store_cmd = CMD_NONE;
        endcase
    end

    // ====================
    // Sequencer FSM
    // ====================
    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            state               <= S_IDLE;
            blk                 <= 1'b0;
            store_write_trigger <= 1'b0;
            capture_done        <= 1'b0;
            rd_x                <= '0;
            rd_y                <= '0;
        end else begin
            // Store is in read mode once the read command has passed
            capture_done <= (state == S_ISSUE_READ);

            case (state)
                S_ISSUE_WRITE: begin
                    store_write_trigger <= 1'b0;
                    state               <= S_WAIT_READY;
                end
                S_WAIT_READY: if (store_write_ready) state <= S_SYNC;
                // pixel_capture flushes the input FIFO during this cycle
                S_SYNC: state <= S_COPY;
                S_COPY: begin
                    if (store_write_ready && store_write_trigger) store_write_trigger <= 1'b0;
                    if (in_read_ready && in_read_trigger) store_write_trigger <= 1'b1;
                    if (!in_read_ready && frame_done && in_read_trigger) state <= S_ISSUE_READ;
                end
                S_ISSUE_READ: begin
                    rd_x  <= image_width;
                    rd_y  <= image_height;
                    state <= (image_height == '0) ? S_IDLE : S_READOUT;
                end
                S_READOUT: begin
                    if (handoff) begin
                        rd_x <= rd_x - 1'b1;
                        if (rd_x == WIDTH_W'(1)) begin
                            rd_x <= image_width;
                            rd_y <= rd_y - 1'b1;
                        end
                    end
                    if (last_word) state <= S_IDLE;
                end
                default: ;
            endcase

            if (cmd_capture) begin
                state <= S_ISSUE_WRITE;
                blk   <= cmd_ram_block;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_read_ready && in_read_trigger) store_write_data <= in_read_data;
    end

    assert property (@(posedge clk) disable iff (!fifoIn_rst) state <= S_READOUT);

endmodule

/* src/img_capture.sv */
`timescale 1ns/100ps

module img_capture
    import img_pkg::*;
(
    input  logic                clk,
    input  logic                fifoIn_rst,
    input  logic                cmd_capture,
    input  logic                cmd_ram_block,
    input  logic [PIXEL_W-1:0]  img_d,
    input  logic                img_fv,
    input  logic                img_lv,
    output logic                readout_ready,
    input  logic                readout_trigger,
    output logic [WORD_W-1:0]   readout_data,
    output logic                capture_done,
    output logic [WIDTH_W-1:0]  image_width,
    output logic [HEIGHT_W-1:0] image_height,
    output logic [STAT_W-1:0]   highlight_count,
    output logic [STAT_W-1:0]   shadow_count
);
    // Pixel side to input FIFO
    logic              in_flush;
    logic              in_write_ready;
    logic              in_write_trigger;
    logic [WORD_W-1:0] in_write_data;
    logic              in_read_ready;
    logic              in_read_trigger;
    logic [WORD_W-1:0] in_read_data;

    // Store streams and control
    logic [CMD_W-1:0]  store_cmd;
    logic              store_block;
    logic              store_write_ready;
    logic              store_write_trigger;
    logic [WORD_W-1:0] store_write_data;
    logic              store_read_ready;
    logic [WORD_W-1:0] store_read_data;
    logic              out_write_ready;
    logic              out_flush;
    logic              capture_start;
    logic              frame_done;

    pixel_capture u_pixel_capture (
        .clk, .fifoIn_rst, .capture_start, .img_d, .img_fv, .img_lv,
        .in_flush, .in_write_ready, .in_write_trigger, .in_write_data,
        .frame_done, .image_width, .image_height, .highlight_count, .shadow_count
    );

    word_fifo u_fifo_in (
        .clk, .fifoIn_rst, .flush(in_flush),
        .write_ready(in_write_ready), .write_trigger(in_write_trigger),
        .write_data(in_write_data),
        .read_ready(in_read_ready), .read_trigger(in_read_trigger), .read_data(in_read_data)
    );

    capture_sequencer u_capture_sequencer (
        .clk, .fifoIn_rst, .cmd_capture, .cmd_ram_block, .capture_start, .frame_done,
        .image_width, .image_height, .in_read_ready, .in_read_trigger, .in_read_data,
        .store_cmd, .store_block, .store_write_ready, .store_write_trigger,
        .store_write_data, .store_read_ready, .out_write_ready, .out_flush, .capture_done
    );

    // Store read stream runs straight into the output FIFO
    frame_store u_frame_store (
        .clk, .fifoIn_rst, .cmd(store_cmd), .block(store_block),
        .write_ready(store_write_ready), .write_trigger(store_write_trigger),
        .write_data(store_write_data),
        .read_ready(store_read_ready), .read_trigger(out_write_ready),
        .read_data(store_read_data)
    );

    word_fifo u_fifo_out (
        .clk, .fifoIn_rst, .flush(out_flush),
        .write_ready(out_write_ready), .write_trigger(store_read_ready),
        .write_data(store_read_data),
        .read_ready(readout_ready), .read_trigger(readout_trigger), .read_data(readout_data)
    );

endmodule

/* bench/img_capture_tb.sv */
`timescale 1ns/100ps

module img_capture_tb
    import img_pkg::*;
();
    localparam int N_FRAMES        = 4;
    localparam int DONE_TIMEOUT    = 500;
    localparam int READOUT_TIMEOUT = 8000;
    localparam int IDLE_CHECK      = 20;

    logic                clk;
    logic                fifoIn_rst;
    logic                cmd_capture;
    logic                cmd_ram_block;
    logic [PIXEL_W-1:0]  img_d;
    logic                img_fv;
    logic                img_lv;
    logic                readout_ready;
    logic                readout_trigger;
    logic [WORD_W-1:0]   readout_data;
    logic                capture_done;
    logic [WIDTH_W-1:0]  image_width;
    logic [HEIGHT_W-1:0] image_height;
    logic [STAT_W-1:0]   highlight_count;
    logic [STAT_W-1:0]   shadow_count;

    // Hex fields of width, height, block, line gap and extreme pixels
    logic [27:0]       frame_table [N_FRAMES];
    logic [WORD_W-1:0] exp_words [BLOCK_SIZE];
    logic [31:0]       lcg_state;
    int                exp_highlight;
    int                exp_shadow;
    int                value_errors;
    int                timeouts;

    img_capture u_img_capture (
        .clk, .fifoIn_rst, .cmd_capture, .cmd_ram_block, .img_d, .img_fv, .img_lv,
        .readout_ready, .readout_trigger, .readout_data, .capture_done,
        .image_width, .image_height, .highlight_count, .shadow_count
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        value_errors++;
        $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
    endtask

    // Line valid low with junk on the data bus
    task automatic drive_blank(input int n);
        repeat (n) begin
            @(posedge clk);
            img_lv <= 1'b0;
            img_d  <= PIXEL_W'(next_rand() >> 20);
        end
    endtask

    // ====================
    // Frame generator
    // ====================
    task automatic drive_frame(input int w, input int h, input int gap, input logic extreme);
        logic [PIXEL_W-1:0] pix;
        int                 idx;
        idx           = 0;
        exp_highlight = 0;
        exp_shadow    = 0;
        @(posedge clk);
        img_fv <= 1'b1;
        for (int y = 0; y < h; y++) begin
            drive_blank(gap);
            for (int x = 0; x < w; x++) begin
                pix = PIXEL_W'(next_rand() >> 20);
                // Grid pixels alternate between shadow and highlight
                if (extreme && x % 4 == 0 && y % 4 == 0) begin
                    pix[PIXEL_W-1 -: STAT_BITS] = ((x / 4 + y / 4) % 2 == 0) ?
                        {STAT_BITS{1'b0}} : {STAT_BITS{1'b1}};
                end
                if (x % 4 == 0 && y % 4 == 0) begin
                    if (pix[PIXEL_W-1 -: STAT_BITS] == {STAT_BITS{1'b1}}) exp_highlight++;
                    if (pix[PIXEL_W-1 -: STAT_BITS] == {STAT_BITS{1'b0}}) exp_shadow++;
                end
                exp_words[idx] = {4'h0, pix};
                idx++;
                @(posedge clk);
                img_lv <= 1'b1;
                img_d  <= pix;
            end
        end
        drive_blank(gap);
        @(posedge clk);
        img_fv <= 1'b0;
    endtask

    task automatic wait_capture_done(output bit seen);
        seen = 1'b0;
        for (int n = 0; n < DONE_TIMEOUT && !seen; n++) begin
            @(negedge clk);
            seen = capture_done;
        end
        if (!seen) begin
            timeouts++;
            $display("Timeout: capture_done did not pulse after the frame ended");
        end
    endtask

    // ====================
    // Readout checker
    // ====================
    task automatic read_frame(input int total);
        int got;
        int cycles;
        got    = 0;
        cycles = 0;
        while (got < total && cycles < READOUT_TIMEOUT) begin
            @(posedge clk);
            readout_trigger <= ((next_rand() >> 30) != 0);
            // Word moves on the next edge when both are high here
            @(negedge clk);
            if (readout_ready && readout_trigger) begin
                if (readout_data !== exp_words[got]) begin
                    report_mismatch($sformatf("readout_data[%0d]", got), readout_data,
                                    exp_words[got]);
                end
                got++;
            end
            cycles++;
        end
        @(posedge clk);
        readout_trigger <= 1'b0;
        if (got < total) begin
            timeouts++;
            $display("Timeout: readout stopped after %0d of %0d words", got, total);
        end
        repeat (IDLE_CHECK) begin
            @(negedge clk);
            if (readout_ready !== 1'b0) report_mismatch("readout_ready", readout_ready, 0);
        end
    endtask

    initial begin
        int   w;
        int   h;
        int   gap;
        logic blk;
        logic ext;
        bit   seen;
        clk             = 1'b0;
        fifoIn_rst      = 1'b0;
        cmd_capture     = 1'b0;
        cmd_ram_block   = 1'b0;
        img_d           = '0;
        img_fv          = 1'b0;
        img_lv          = 1'b0;
        readout_trigger = 1'b0;
        lcg_state       = 32'hb0225b1b;
        value_errors    = 0;
        timeouts        = 0;

        frame_table[0] = 28'h08_06_0_2_1;
        frame_table[1] = 28'h0d_09_1_1_0;
        frame_table[2] = 28'h20_20_0_3_1;
        frame_table[3] = 28'h05_11_1_4_1;

        repeat (10) @(posedge clk);
        fifoIn_rst <= 1'b1;

        // Quiet outputs before the first command
        repeat (5) begin
            @(negedge clk);
            if (capture_done !== 1'b0) report_mismatch("capture_done", capture_done, 0);
            if (readout_ready !== 1'b0) report_mismatch("readout_ready", readout_ready, 0);
        end

        for (int i = 0; i < N_FRAMES; i++) begin
            w   = frame_table[i][27:20];
            h   = frame_table[i][19:12];
            blk = frame_table[i][8];
            gap = frame_table[i][7:4];
            ext = frame_table[i][0];

            @(posedge clk);
            cmd_capture   <= 1'b1;
            cmd_ram_block <= blk;
            img_fv        <= 1'b1;
            img_lv        <= 1'b0;
            @(posedge clk);
            cmd_capture <= 1'b0;
            // Frame valid is already high, so capture must see it drop first
            repeat (100) @(posedge clk);
            img_fv <= 1'b0;
            drive_blank(3);
            drive_frame(w, h, gap, ext);

            wait_capture_done(seen);
            if (!seen) break;
            if (image_width !== WIDTH_W'(w)) report_mismatch("image_width", image_width, w);
            if (image_height !== HEIGHT_W'(h)) report_mismatch("image_height", image_height, h);
            if (highlight_count !== STAT_W'(exp_highlight)) begin
                report_mismatch("highlight_count", highlight_count, exp_highlight);
            end
            if (shadow_count !== STAT_W'(exp_shadow)) begin
                report_mismatch("shadow_count", shadow_count, exp_shadow);
            end

            read_frame(w * h);
            if (timeouts != 0) break;
        end

        $display("Value errors: %0d, timeouts: %0d", value_errors, timeouts);
        if (value_errors == 0 && timeouts == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* img_capture.f */
src/img_pkg.sv
src/word_fifo.sv
src/pixel_capture.sv
src/frame_store.sv
src/capture_sequencer.sv
src/img_capture.sv
bench/img_capture_tb.sv

/* Bender.yml */
package:
  name: img_capture

sources:
  - src/img_pkg.sv
  - src/word_fifo.sv
  - src/pixel_capture.sv
  - src/frame_store.sv
  - src/capture_sequencer.sv
  - src/img_capture.sv
  - target: test
    files:
      - bench/img_capture_tb.sv
